/* design/aesDecryptSettings.svh */
`ifndef AES_DECRYPT_SETTINGS_SVH
`define AES_DECRYPT_SETTINGS_SVH

// **************************************************
// AES-128 geometry
// **************************************************

// Columns of 32 bits per state
`define AES_NB 4

// 32-bit words in the cipher key
`define AES_NK 4

`define AES_NR 10  // Inverse rounds after the initial key addition

// Words in the expanded schedule, NB * (NR + 1)
`define AES_KEY_WORDS 44

`endif

/* design/aesPkg.sv */
`default_nettype none

package aesPkg;

    // **************************************************
    // Vector types
    // **************************************************

    typedef logic [7:0]   byte_t;      // One state byte
    typedef logic [31:0]  word_t;      // Column or schedule word
    typedef logic [127:0] block_t;     // Byte 0 in bits 127:120
    typedef logic [3:0]   roundIdx_t;  // Round 0 to 10
    typedef logic [5:0]   wordIdx_t;   // Schedule word 0 to 43

    typedef enum logic [2:0] {
        stIdle,
        stExpand,
        stInitial,
        stRounds,
        stHold
    } coreState_t;

    // **************************************************
    // GF(2^8) arithmetic, polynomial x^8+x^4+x^3+x+1
    // **************************************************

    function automatic byte_t gfMul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t pow;
        acc = '0;
        pow = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc ^= pow;
            pow = {pow[6:0], 1'b0} ^ (pow[7] ? 8'h1b : 8'h00);  // xtime
        end
        return acc;
    endfunction

    // a^254 by repeated squaring, maps 0 to 0
    function automatic byte_t gfInv(input byte_t a);
        byte_t result;
        byte_t square;
        result = 8'h01;
        square = a;
        for (int i = 0; i < 7; i++)
        begin
            square = gfMul(square, square);
            result = gfMul(result, square);
        end
        return result;
    endfunction

    // Forward S-box, used by the key schedule
    function automatic byte_t subByte(input byte_t x);
        byte_t y;
        y = gfInv(x);
        return y ^ {y[6:0], y[7]} ^ {y[5:0], y[7:6]} ^ {y[4:0], y[7:5]}
                 ^ {y[3:0], y[7:4]} ^ 8'h63;
    endfunction

    function automatic byte_t invSubByte(input byte_t x);
        byte_t z;
        z = {x[6:0], x[7]} ^ {x[4:0], x[7:5]} ^ {x[1:0], x[7:2]} ^ 8'h05;  // Inverse affine
        return gfInv(z);
    endfunction

endpackage

`default_nettype wire

/* design/blockIngress.sv */
`timescale 1ns/100ps
`default_nettype none

module blockIngress import aesPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   inReq,
    input  block_t cipherIn,
    input  block_t keyIn,
    input  logic   coreIdle,
    output logic   inAck,
    output logic   startPulse,
    output block_t cipherBlock,
    output block_t cipherKey,
    output logic   keyChanged
);

    logic accept;
    logic keyValid;

    assign accept = inReq & ~inAck & coreIdle;  // New request, core ready

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inAck      <= 1'b0;
            startPulse <= 1'b0;
            keyValid   <= 1'b0;
        end
        else
        begin
            startPulse <= accept;
            if (accept)
            begin
                inAck    <= 1'b1;
                keyValid <= 1'b1;
            end
            else if (inAck && !inReq)
                inAck <= 1'b0;  // Phase 4
        end
    end

    // cipherKey doubles as the last accepted key
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cipherBlock <= cipherIn;
            cipherKey   <= keyIn;
            keyChanged  <= !keyValid || (keyIn != cipherKey);
        end
    end

endmodule

`default_nettype wire

/* design/keyExpander.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aesDecryptSettings.svh"

module keyExpander import aesPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      expandStart,
    input  block_t    cipherKey,
    input  roundIdx_t roundSel,
    output logic      expandBusy,
    output block_t    roundKey
);

    word_t    keyWords [`AES_KEY_WORDS];
    wordIdx_t wordIdx;      // Word written this cycle
    byte_t    rcon;
    word_t    prevWord;
    word_t    rotWord;
    word_t    subWord;
    word_t    nextWord;
    logic     rconStep;
    wordIdx_t baseIdx;

    assign prevWord = keyWords[wordIdx - wordIdx_t'(1)];
    assign rotWord  = {prevWord[23:0], prevWord[31:24]};
    assign rconStep = (wordIdx % wordIdx_t'(`AES_NK)) == '0;

    always_comb
    begin
        for (int b = 0; b < 4; b++)
            subWord[31 - 8*b -: 8] = subByte(rotWord[31 - 8*b -: 8]);
    end

    assign nextWord = keyWords[wordIdx - wordIdx_t'(`AES_NK)]
                    ^ (rconStep ? (subWord ^ {rcon, 24'h000000}) : prevWord);

    always_ff @(posedge clk)
    begin
        if (expandStart)
        begin
            for (int k = 0; k < `AES_NK; k++)
                keyWords[k] <= cipherKey[127 - 32*k -: 32];
        end
        else if (expandBusy)
            keyWords[wordIdx] <= nextWord;
    end

    always_ff @(posedge clk)
    begin
        if (expandStart)
        begin
            wordIdx <= wordIdx_t'(`AES_NK);
            rcon    <= 8'h01;
        end
        else if (expandBusy)
        begin
            wordIdx <= wordIdx + wordIdx_t'(1);
            if (rconStep)
                rcon <= gfMul(rcon, 8'h02);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            expandBusy <= 1'b0;
        else if (expandStart)
            expandBusy <= 1'b1;
        else if (expandBusy && wordIdx == wordIdx_t'(`AES_KEY_WORDS - 1))
            expandBusy <= 1'b0;  // Last word written
    end

    assign baseIdx  = {roundSel, 2'b00};
    assign roundKey = {keyWords[baseIdx], keyWords[baseIdx + wordIdx_t'(1)],
                       keyWords[baseIdx + wordIdx_t'(2)], keyWords[baseIdx + wordIdx_t'(3)]};

endmodule

`default_nettype wire

/* design/invRoundUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aesDecryptSettings.svh"

module invRoundUnit import aesPkg::*; (
    input  block_t stateIn,
    input  block_t roundKey,
    input  logic   lastRound,
    output block_t stateOut
);

    localparam word_t mixCoef = 32'h0e0b0d09;  // First row of InvMixColumns

    block_t subState;
    block_t keyedState;
    block_t mixedState;

    // InvShiftRows and InvSubBytes, row r moves right by r
    always_comb
    begin
        for (int c = 0; c < `AES_NB; c++)
        begin
            for (int r = 0; r < 4; r++)
                subState[127 - 8*(4*c + r) -: 8] =
                    invSubByte(stateIn[127 - 8*(4*((c - r + `AES_NB) % `AES_NB) + r) -: 8]);
        end
    end

    assign keyedState = subState ^ roundKey;

    // Each row uses the coefficient row rotated right by r
    always_comb
    begin
        byte_t acc;
        for (int c = 0; c < `AES_NB; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                acc = '0;
                for (int j = 0; j < 4; j++)
                    acc ^= gfMul(mixCoef[31 - 8*((j - r + 4) % 4) -: 8],
                                 keyedState[127 - 8*(4*c + j) -: 8]);
                mixedState[127 - 8*(4*c + r) -: 8] = acc;
            end
        end
    end

    assign stateOut = lastRound ? keyedState : mixedState;  // No mixing in round 0

endmodule

`default_nettype wire

/* design/decryptCore.sv */
`timescale 1ns/100ps
`default_nettype none

`include "aesDecryptSettings.svh"

module decryptCore import aesPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   startPulse,
    input  block_t cipherBlock,
    input  block_t cipherKey,
    input  logic   keyChanged,
    input  logic   egressFree,
    output logic   coreIdle,
    output logic   resultValid,
    output block_t plainBlock
);

    coreState_t coreState;
    roundIdx_t  roundCnt;    // Also selects the round key
    block_t     stateReg;
    block_t     roundKey;
    block_t     roundOut;
    logic       expandStart;
    logic       expandBusy;
    logic       lastRound;

    assign expandStart = startPulse & keyChanged;
    assign lastRound   = (roundCnt == '0);
    assign coreIdle    = (coreState == stIdle);
    assign resultValid = (coreState == stHold) & egressFree;
    assign plainBlock  = stateReg;

    keyExpander keyExp0 (
        .clk        (clk),
        .reset      (reset),
        .expandStart(expandStart),
        .cipherKey  (cipherKey),
        .roundSel   (roundCnt),
        .expandBusy (expandBusy),
        .roundKey   (roundKey)
    );

    invRoundUnit round0 (
        .stateIn  (stateReg),
        .roundKey (roundKey),
        .lastRound(lastRound),
        .stateOut (roundOut)
    );

    // **************************************************
    // Control FSM
    // **************************************************

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            coreState <= stIdle;
            roundCnt  <= '0;
        end
        else
        begin
            case (coreState)
                stIdle:
                begin
                    if (startPulse)
                    begin
                        roundCnt  <= roundIdx_t'(`AES_NR);
                        coreState <= keyChanged ? stExpand : stInitial;
                    end
                end
                stExpand:
                    if (!expandBusy)
                        coreState <= stInitial;
                stInitial:
                begin
                    roundCnt  <= roundCnt - roundIdx_t'(1);
                    coreState <= stRounds;
                end
                stRounds:
                begin
                    if (lastRound)
                        coreState <= stHold;
                    else
                        roundCnt <= roundCnt - roundIdx_t'(1);
                end
                stHold:
                    if (egressFree)
                        coreState <= stIdle;  // Handed to egress
                default:
                    coreState <= stIdle;
            endcase
        end
    end

    // **************************************************
    // State register
    // **************************************************

    always_ff @(posedge clk)
    begin
        case (coreState)
            stIdle:    if (startPulse) stateReg <= cipherBlock;
            stInitial: stateReg <= stateReg ^ roundKey;  // Round key 10
            stRounds:  stateReg <= roundOut;
            default:   stateReg <= stateReg;
        endcase
    end

endmodule

`default_nettype wire

/* design/blockEgress.sv */
`timescale 1ns/100ps
`default_nettype none

module blockEgress import aesPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   resultValid,
    input  block_t plainBlock,
    input  logic   outAck,
    output logic   egressFree,
    output logic   outReq,
    output block_t plainOut
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outReq     <= 1'b0;
            egressFree <= 1'b1;
        end
        else if (resultValid)
        begin
            outReq     <= 1'b1;
            egressFree <= 1'b0;
        end
        else if (outReq && outAck)
            outReq <= 1'b0;      // Phase 3
        else if (!egressFree && !outReq && !outAck)
            egressFree <= 1'b1;  // Consumer done
    end

    // Held until the next result
    always_ff @(posedge clk)
    begin
        if (resultValid)
            plainOut <= plainBlock;
    end

endmodule

`default_nettype wire

/* design/aesDecryptTop.sv */
`timescale 1ns/100ps
`default_nettype none

module aesDecryptTop import aesPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   inReq,
    input  block_t cipherIn,
    input  block_t keyIn,
    input  logic   outAck,
    output logic   inAck,
    output logic   outReq,
    output block_t plainOut
);

    logic   startPulse;
    logic   keyChanged;
    logic   coreIdle;
    logic   resultValid;
    logic   egressFree;
    block_t cipherBlock;
    block_t cipherKey;
    block_t plainBlock;

    blockIngress ingress0 (
        .clk        (clk),
        .reset      (reset),
        .inReq      (inReq),
        .cipherIn   (cipherIn),
        .keyIn      (keyIn),
        .coreIdle   (coreIdle),
        .inAck      (inAck),
        .startPulse (startPulse),
        .cipherBlock(cipherBlock),
        .cipherKey  (cipherKey),
        .keyChanged (keyChanged)
    );

    decryptCore core0 (
        .clk        (clk),
        .reset      (reset),
        .startPulse (startPulse),
        .cipherBlock(cipherBlock),
        .cipherKey  (cipherKey),
        .keyChanged (keyChanged),
        .egressFree (egressFree),
        .coreIdle   (coreIdle),
        .resultValid(resultValid),
        .plainBlock (plainBlock)
    );

    blockEgress egress0 (
        .clk        (clk),
        .reset      (reset),
        .resultValid(resultValid),
        .plainBlock (plainBlock),
        .outAck     (outAck),
        .egressFree (egressFree),
        .outReq     (outReq),
        .plainOut   (plainOut)
    );

endmodule

`default_nettype wire

/* tests/aesDecryptTb.sv */
`timescale 1ns/100ps
`default_nettype none

module aesDecryptTb import aesPkg::*; ();

    localparam int   handshakeLimit = 200;             // Cycles per handshake phase
    localparam int   cycleLimit     = 6 * 200;         // 6 tests, 200 cycles each
    localparam int   selInAck       = 0;
    localparam int   selOutReq      = 1;
    localparam logic [31:0] rngSeed = 32'h9314f4bc;

    localparam block_t keyC1    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t cipherC1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam block_t plainC1  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t keyB     = 128'h2b7e151628aed2a6abf7158809cf4f3c;

    logic   clk;
    logic   reset;
    logic   inReq;
    block_t cipherIn;
    block_t keyIn;
    logic   outAck;
    logic   inAck;
    logic   outReq;
    block_t plainOut;

    int     errorCount   = 0;
    int     errorsBefore = 0;
    int     testCount    = 0;
    int     failedTests  = 0;
    int     cycleCount   = 0;
    logic   monitorOn    = 1'b0;
    logic   lastInReq;
    logic   lastInAck;
    logic   lastOutReq;
    logic   lastOutAck;
    block_t lastPlainOut;

    aesDecryptTop dut0 (
        .clk     (clk),
        .reset   (reset),
        .inReq   (inReq),
        .cipherIn(cipherIn),
        .keyIn   (keyIn),
        .outAck  (outAck),
        .inAck   (inAck),
        .outReq  (outReq),
        .plainOut(plainOut)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // **************************************************
    // Checks and helpers
    // **************************************************

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic compareBlock(input string name, input block_t got, input block_t expected);
        if (got !== expected)
        begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #0.5;  // Drive point
    endtask

    function automatic logic portLevel(input int sel);
        return (sel == selInAck) ? inAck : outReq;
    endfunction

    task automatic awaitLevel(input string name, input int sel, input logic level);
        int timer;
        timer = 0;
        while (portLevel(sel) !== level && timer < handshakeLimit)
        begin
            stepCycle();
            timer++;
        end
        if (portLevel(sel) !== level)
        begin
            $display("Handshake stuck: %s did not go to %0d within %0d cycles",
                     name, level, handshakeLimit);
            errorCount++;
        end
    endtask

    task automatic sendBlock(input block_t cipher, input block_t key);
        stepCycle();
        cipherIn = cipher;
        keyIn    = key;
        inReq    = 1'b1;
        awaitLevel("inAck", selInAck, 1'b1);
        inReq = 1'b0;
        awaitLevel("inAck", selInAck, 1'b0);
    endtask

    task automatic receiveBlock(input logic stall, output block_t data);
        awaitLevel("outReq", selOutReq, 1'b1);
        if (stall)
            repeat ($urandom % 21) stepCycle();
        data   = plainOut;
        outAck = 1'b1;
        awaitLevel("outReq", selOutReq, 1'b0);
        outAck = 1'b0;
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == errorsBefore)
            $display("Test %0d %s: ok", testCount, name);
        else
        begin
            failedTests++;
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
        errorsBefore = errorCount;
    endtask

    // Four-phase rules and output stability, sampled mid-cycle
    always @(negedge clk)
    begin
        if (monitorOn)
        begin
            if (lastInAck && !inAck)
                compareBit("inReq before inAck fall", lastInReq, 1'b0);
            if (lastOutReq && !outReq)
                compareBit("outAck before outReq fall", lastOutAck, 1'b1);
            if (lastOutReq && outReq)
                compareBlock("plainOut while outReq", plainOut, lastPlainOut);
        end
        lastInReq    = inReq;
        lastInAck    = inAck;
        lastOutReq   = outReq;
        lastOutAck   = outAck;
        lastPlainOut = plainOut;
    end

    // **************************************************
    // Directed tests
    // **************************************************

    task automatic decryptOne(input block_t key, input block_t cipher, input block_t plain);
        block_t got;
        sendBlock(cipher, key);
        receiveBlock(1'b0, got);
        compareBlock("plainOut", got, plain);
    endtask

    task automatic backPressureTest();
        block_t cipherList [5];
        block_t plainList [5];
        block_t got;
        cipherList[0] = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
        cipherList[1] = 128'hf5d3d58503b9699de785895a96fdbaaf;
        cipherList[2] = 128'h43b1cd7f598ece23881b00e3ed030688;
        cipherList[3] = 128'h7b0c785e27e8ad3f8223207104725dd4;
        cipherList[4] = 128'h3925841d02dc09fbdc118597196a0b32;
        plainList[0]  = 128'h6bc1bee22e409f96e93d7e117393172a;
        plainList[1]  = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
        plainList[2]  = 128'h30c81c46a35ce411e5fbc1191a0a52ef;
        plainList[3]  = 128'hf69f2445df4f9b17ad2b417be66c3710;
        plainList[4]  = 128'h3243f6a8885a308d313198a2e0370734;
        fork
            for (int i = 0; i < 5; i++)
                sendBlock(cipherList[i], keyB);
            for (int i = 0; i < 5; i++)
            begin
                receiveBlock(1'b1, got);
                compareBlock("plainOut", got, plainList[i]);
            end
        join
    endtask

    task automatic protocolTest();
        block_t got;
        stepCycle();
        cipherIn = cipherC1;
        keyIn    = keyC1;  // Key change forces expansion
        inReq    = 1'b1;
        awaitLevel("inAck", selInAck, 1'b1);
        repeat (3)
        begin
            stepCycle();
            compareBit("inAck", inAck, 1'b1);  // Held while inReq high
        end
        inReq = 1'b0;
        awaitLevel("inAck", selInAck, 1'b0);
        awaitLevel("outReq", selOutReq, 1'b1);
        repeat (5)
        begin
            stepCycle();
            compareBit("outReq", outReq, 1'b1);  // Waits for outAck
        end
        got    = plainOut;
        outAck = 1'b1;
        awaitLevel("outReq", selOutReq, 1'b0);
        repeat (3)
        begin
            stepCycle();
            compareBit("outReq", outReq, 1'b0);
        end
        outAck = 1'b0;
        stepCycle();
        compareBlock("plainOut", got, plainC1);
    endtask

    initial
    begin
        void'($urandom(rngSeed));
        clk      = 1'b0;
        reset    = 1'b1;
        inReq    = 1'b0;
        cipherIn = '0;
        keyIn    = '0;
        outAck   = 1'b0;
        repeat (4) @(posedge clk);
        #0.5;
        reset     = 1'b0;
        monitorOn = 1'b1;

        stepCycle();
        compareBit("inAck", inAck, 1'b0);
        compareBit("outReq", outReq, 1'b0);
        reportTest("reset state");

        decryptOne(keyC1, cipherC1, plainC1);
        reportTest("FIPS-197 C.1");

        decryptOne('0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, '0);
        decryptOne(keyC1, cipherC1, plainC1);
        reportTest("key change");

        decryptOne(keyB, 128'h3ad77bb40d7a3660a89ecaf32466ef97,
                   128'h6bc1bee22e409f96e93d7e117393172a);
        decryptOne(keyB, 128'hf5d3d58503b9699de785895a96fdbaaf,
                   128'hae2d8a571e03ac9c9eb76fac45af8e51);
        reportTest("key reuse");

        backPressureTest();
        reportTest("back-pressure");

        protocolTest();
        reportTest("handshake protocol");

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* aesDecryptTop.f */
+incdir+design
design/aesPkg.sv
design/blockIngress.sv
design/keyExpander.sv
design/invRoundUnit.sv
design/decryptCore.sv
design/blockEgress.sv
design/aesDecryptTop.sv
tests/aesDecryptTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f aesDecryptTop.f --top-module aesDecryptTb \
    -Mdir obj_dir -o simAes > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simAes > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } || exit 0
